/* all.f */
source/ps_pkg.sv
source/command_decoder.sv
source/address_translator.sv
source/hp0_memory.sv
source/ps_subsystem.sv
bench/clock_source.sv
bench/ps_subsystem_tb.sv

/* Bender.yml */
package:
  name: ps_subsystem

sources:
  - files:
      - source/ps_pkg.sv
      - source/command_decoder.sv
      - source/address_translator.sv
      - source/hp0_memory.sv
      - source/ps_subsystem.sv

  - target: simulation
    files:
      - bench/clock_source.sv
      - bench/ps_subsystem_tb.sv

/* bench/ps_subsystem_tb.sv */
module ps_subsystem_tb
    import ps_pkg::*;
();

    localparam int random_operations = 300;
    localparam int region_words = 64;
    localparam int response_latency = 3;

    logic                         peripheral_clock;
    logic                         reset;
    logic                         reg_write;
    logic [reg_address_width-1:0] reg_address;
    logic [data_width-1:0]        reg_write_data;
    logic                         resp_valid;
    logic [data_width-1:0]        resp_data;
    logic                         resp_error;

    int     cycle_count = 0;
    int     issued_operations = 0;
    int     response_count = 0;
    int     value_errors = 0;
    int     timing_errors = 0;
    int     other_errors = 0;
    integer seed = 32'hc51b;

    logic [hp0_addr_width-1:0] model_offset;
    logic [data_width-1:0]     model_staged;
    logic [data_width-1:0]     model_words [mem_depth];

    logic [data_width-1:0] expected_data_q [$];
    logic                  expected_error_q [$];
    int                    issue_cycle_q [$]; // Cycle in which the read strobe was driven.

    clock_source clock_source_i (
        .peripheral_clock (peripheral_clock),
        .reset            (reset)
    );

    ps_subsystem ps_subsystem_i (
        .peripheral_clock (peripheral_clock),
        .reset            (reset),
        .reg_write        (reg_write),
        .reg_address      (reg_address),
        .reg_write_data   (reg_write_data),
        .resp_valid       (resp_valid),
        .resp_data        (resp_data),
        .resp_error       (resp_error)
    );

    always @(posedge peripheral_clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Applies one register write to the model; returns 1 for a read, with its expected result.
    function automatic logic reference_result(
        input  logic [reg_address_width-1:0] address,
        input  logic [data_width-1:0]        data,
        output logic [data_width-1:0]        read_data,
        output logic                         read_error
    );
        logic [hp0_addr_width-1:0] target;
        logic                      outside;
        read_data = '0;
        read_error = 1'b0;
        if (address == reg_data_address) begin
            model_staged = data;
            return 1'b0;
        end
        if (data[31]) begin
            model_offset = data[hp0_addr_width-1:0];
            return 1'b0;
        end
        target = data[hp0_addr_width-1:0] + model_offset; // Wraps at the port width.
        outside = target >= mem_depth;
        if (data[30]) begin
            if (!outside) begin
                model_words[target[mem_index_width-1:0]] = model_staged;
            end
            return 1'b0;
        end
        read_error = outside;
        read_data = outside ? '0 : model_words[target[mem_index_width-1:0]];
        return 1'b1;
    endfunction

    function automatic logic [data_width-1:0] fill_pattern(input logic [hp0_addr_width-1:0] a);
        return {a ^ 16'h5a5a, ~a};
    endfunction

    task automatic strobe_register(input logic [reg_address_width-1:0] address,
                                   input logic [data_width-1:0] data);
        logic [data_width-1:0] read_data;
        logic                  read_error;
        @(negedge peripheral_clock);
        reg_write = 1'b1;
        reg_address = address;
        reg_write_data = data;
        issued_operations++;
        if (reference_result(address, data, read_data, read_error)) begin
            expected_data_q.push_back(read_data);
            expected_error_q.push_back(read_error);
            issue_cycle_q.push_back(cycle_count);
        end
    endtask

    task automatic stage_data(input logic [data_width-1:0] data);
        strobe_register(reg_data_address, data);
    endtask

    task automatic set_offset(input logic [hp0_addr_width-1:0] offset);
        strobe_register(reg_command_address, {1'b1, 15'b0, offset});
    endtask

    task automatic write_access(input logic [hp0_addr_width-1:0] address);
        strobe_register(reg_command_address, {2'b01, 14'b0, address});
    endtask

    task automatic read_access(input logic [hp0_addr_width-1:0] address);
        strobe_register(reg_command_address, {2'b00, 14'b0, address});
    endtask

    task automatic store_word(input logic [hp0_addr_width-1:0] address,
                              input logic [data_width-1:0] data);
        stage_data(data);
        write_access(address);
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(negedge peripheral_clock);
            reg_write = 1'b0;
        end
    endtask

    // Targets land in the preloaded region or outside the window, whatever the offset is.
    task automatic random_operation();
        int                        choice;
        logic [hp0_addr_width-1:0] target;
        choice = $unsigned($random(seed)) % 8;
        if ($unsigned($random(seed)) % 4 == 0) begin
            target = 16'(mem_depth + $unsigned($random(seed)) % (65536 - mem_depth));
        end else begin
            target = 16'($unsigned($random(seed)) % region_words);
        end
        case (choice)
            0, 1: stage_data($random(seed));
            2: set_offset(16'($random(seed)));
            3, 4: write_access(target - model_offset);
            default: read_access(target - model_offset);
        endcase
    endtask

    task automatic drop_oldest_read();
        void'(expected_data_q.pop_front());
        void'(expected_error_q.pop_front());
        void'(issue_cycle_q.pop_front());
    endtask

    always @(negedge peripheral_clock) begin
        if (!reset) begin
            if (issue_cycle_q.size() > 0 && cycle_count > issue_cycle_q[0] + response_latency) begin
                other_errors++;
                $display("No response for the read strobed in cycle %0d", issue_cycle_q[0]);
                drop_oldest_read();
            end
            if (resp_valid) begin
                response_count++;
                if (issue_cycle_q.size() == 0) begin
                    other_errors++;
                    $display("Response in cycle %0d with no read outstanding", cycle_count);
                end else begin
                    if (cycle_count != issue_cycle_q[0] + response_latency) begin
                        timing_errors++;
                        $display("Response came in cycle %0d, expected in cycle %0d",
                                 cycle_count, issue_cycle_q[0] + response_latency);
                    end
                    if (resp_data !== expected_data_q[0]) begin
                        value_errors++;
                        $display("Error resp_data expected %h actual %h",
                                 expected_data_q[0], resp_data);
                    end
                    if (resp_error !== expected_error_q[0]) begin
                        value_errors++;
                        $display("Error resp_error expected %h actual %h",
                                 expected_error_q[0], resp_error);
                    end
                    drop_oldest_read();
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_count > issued_operations * 10 + 200);
        $display("Watchdog ended the run after %0d cycles and %0d operations",
                 cycle_count, issued_operations);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        int i;
        reg_write = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        model_offset = '0;
        model_staged = '0;
        wait (reset === 1'b0);

        repeat (20) begin
            @(negedge peripheral_clock);
            if (resp_valid !== 1'b0) begin
                other_errors++;
                $display("resp_valid went high with no host activity");
            end
        end

        store_word(16'h0003, 32'h1234_5678);
        store_word(16'h0064, 32'hdead_beef);
        store_word(16'h01ff, 32'h0bad_cafe);
        store_word(16'h03ff, 32'h8000_0001);
        read_access(16'h0003);
        read_access(16'h0064);
        read_access(16'h01ff);
        read_access(16'h03ff);
        go_idle(4);

        set_offset(16'h0100);
        store_word(16'h0010, 32'h0110_0110); // Lands at 0x110.
        read_access(16'h0010);
        set_offset(16'hfff0);
        store_word(16'h0020, 32'h0010_0010); // Wraps round to 0x010.
        read_access(16'h0020);
        set_offset(16'h0000);
        read_access(16'h0110);
        read_access(16'h0010);
        go_idle(4);

        set_offset(16'h0300);
        read_access(16'h0100);
        store_word(16'h0103, 32'hffff_ffff); // Index 3 if it were not dropped.
        set_offset(16'h0000);
        store_word(16'h0464, 32'h5555_aaaa);
        read_access(16'hf000);
        read_access(16'h0003);
        read_access(16'h0064);
        read_access(16'h03ff);
        go_idle(4);

        stage_data(32'hcafe_0001);
        write_access(16'h0020);
        read_access(16'h0020);
        set_offset(16'h0010);
        read_access(16'h0010);
        stage_data(32'hcafe_0002);
        write_access(16'h0010);
        read_access(16'h0010);
        set_offset(16'h0000);
        read_access(16'h0020);
        read_access(16'h0003);
        go_idle(4);

        for (i = 0; i < region_words; i++) begin
            store_word(16'(i), fill_pattern(16'(i)));
        end
        for (i = 0; i < random_operations; i++) begin
            random_operation();
        end
        go_idle(response_latency + 3);

        $display("Responses: %0d, value errors: %0d, timing errors: %0d, other errors: %0d",
                 response_count, value_errors, timing_errors, other_errors);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/clock_source.sv */
module clock_source (
    output logic peripheral_clock,
    output logic reset
);

    localparam int half_period = 50;
    localparam int reset_cycles = 16;

    initial begin
        peripheral_clock = 1'b0;
        forever #half_period peripheral_clock = ~peripheral_clock;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge peripheral_clock);
        @(negedge peripheral_clock);
        reset = 1'b0; // Released between edges, like every other input.
    end

endmodule

/* source/ps_subsystem.sv */
module ps_subsystem
    import ps_pkg::*;
(
    input  logic                         peripheral_clock,
    input  logic                         reset,
    input  logic                         reg_write,
    input  logic [reg_address_width-1:0] reg_address,
    input  logic [data_width-1:0]        reg_write_data,
    output logic                         resp_valid,
    output logic [data_width-1:0]        resp_data,
    output logic                         resp_error
);

    logic                       access_valid;
    logic                       access_write;
    logic [hp0_addr_width-1:0]  access_address;
    logic [hp0_addr_width-1:0]  access_offset;
    logic [data_width-1:0]      access_data;

    logic                       mem_valid;
    logic                       mem_write;
    logic [mem_index_width-1:0] mem_index;
    logic [data_width-1:0]      mem_data;
    logic                       mem_error;

    command_decoder command_decoder_i (
        .peripheral_clock (peripheral_clock),
        .reset            (reset),
        .reg_write        (reg_write),
        .reg_address      (reg_address),
        .reg_write_data   (reg_write_data),
        .access_valid     (access_valid),
        .access_write     (access_write),
        .access_address   (access_address),
        .access_offset    (access_offset),
        .access_data      (access_data)
    );

    address_translator address_translator_i (
        .peripheral_clock (peripheral_clock),
        .reset            (reset),
        .access_valid     (access_valid),
        .access_write     (access_write),
        .access_address   (access_address),
        .access_offset    (access_offset),
        .access_data      (access_data),
        .mem_valid        (mem_valid),
        .mem_write        (mem_write),
        .mem_index        (mem_index),
        .mem_data         (mem_data),
        .mem_error        (mem_error)
    );

    hp0_memory hp0_memory_i (
        .peripheral_clock (peripheral_clock),
        .reset            (reset),
        .mem_valid        (mem_valid),
        .mem_write        (mem_write),
        .mem_index        (mem_index),
        .mem_data         (mem_data),
        .mem_error        (mem_error),
        .resp_valid       (resp_valid),
        .resp_data        (resp_data),
        .resp_error       (resp_error)
    );

endmodule

/* source/hp0_memory.sv */
module hp0_memory
    import ps_pkg::*;
(
    input  logic                       peripheral_clock,
    input  logic                       reset,
    input  logic                       mem_valid,
    input  logic                       mem_write,
    input  logic [mem_index_width-1:0] mem_index,
    input  logic [data_width-1:0]      mem_data,
    input  logic                       mem_error,
    output logic                       resp_valid,
    output logic [data_width-1:0]      resp_data,
    output logic                       resp_error
);

    logic [data_width-1:0] words [mem_depth];
    logic                  store_word;
    logic                  read_access;

    assign store_word  = mem_valid && mem_write && !mem_error; // Out-of-window writes are dropped.
    assign read_access = mem_valid && !mem_write;

    always_ff @(posedge peripheral_clock) begin
        if (store_word) begin
            words[mem_index] <= mem_data;
        end
    end

    // Only reads are answered.
    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= read_access;
        end
    end

    always_ff @(posedge peripheral_clock) begin
        if (read_access) begin
            if (mem_error) begin
                resp_data <= '0;
            end else begin
                resp_data <= words[mem_index];
            end
            resp_error <= mem_error;
        end
    end

endmodule

/* source/address_translator.sv */
module address_translator
    import ps_pkg::*;
(
    input  logic                       peripheral_clock,
    input  logic                       reset,
    input  logic                       access_valid,
    input  logic                       access_write,
    input  logic [hp0_addr_width-1:0]  access_address,
    input  logic [hp0_addr_width-1:0]  access_offset,
    input  logic [data_width-1:0]      access_data,
    output logic                       mem_valid,
    output logic                       mem_write,
    output logic [mem_index_width-1:0] mem_index,
    output logic [data_width-1:0]      mem_data,
    output logic                       mem_error
);

    logic [hp0_addr_width-1:0] translated_address;
    logic                      outside_window;

    // Sum is truncated to the port width, so it wraps.
    assign translated_address = access_address + access_offset;
    assign outside_window = translated_address >= hp0_addr_width'(mem_depth);

    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= access_valid;
        end
    end

    always_ff @(posedge peripheral_clock) begin
        if (access_valid) begin
            mem_write <= access_write;
            mem_index <= translated_address[mem_index_width-1:0];
            mem_data  <= access_data;
            mem_error <= outside_window;
        end
    end

endmodule

/* source/command_decoder.sv */
module command_decoder
    import ps_pkg::*;
(
    input  logic                         peripheral_clock,
    input  logic                         reset,
    input  logic                         reg_write,
    input  logic [reg_address_width-1:0] reg_address,
    input  logic [data_width-1:0]        reg_write_data,
    output logic                         access_valid,
    output logic                         access_write,
    output logic [hp0_addr_width-1:0]    access_address,
    output logic [hp0_addr_width-1:0]    access_offset,
    output logic [data_width-1:0]        access_data
);

    host_command_u               command;
    logic [data_width-1:0]       staged_data;
    logic [hp0_addr_width-1:0]   port_offset;
    logic                        command_write;

    assign command = host_command_u'(reg_write_data);
    assign command_write = reg_write && (reg_address == reg_command_address);

    // Staged write data and the port offset are control state seen by later commands.
    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            staged_data <= '0;
            port_offset <= '0;
        end else if (reg_write) begin
            if (reg_address == reg_data_address) begin
                staged_data <= reg_write_data;
            end else if (command.config_view.kind == command_kind_config) begin
                port_offset <= command.config_view.offset;
            end
        end
    end

    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            access_valid <= 1'b0;
        end else begin
            access_valid <= command_write &&
                            (command.access_view.kind == command_kind_access);
        end
    end

    // The offset taken here is the one in effect before this edge.
    always_ff @(posedge peripheral_clock) begin
        if (command_write) begin
            access_write   <= command.access_view.write;
            access_address <= command.access_view.address;
            access_offset  <= port_offset;
            access_data    <= staged_data; // Data written in an earlier cycle.
        end
    end

endmodule

/* source/ps_pkg.sv */
package ps_pkg;

    localparam int data_width = 32;
    localparam int hp0_addr_width = 16;

    localparam int mem_depth = 1024; // Translated addresses at or above this miss the window.
    localparam int mem_index_width = 10;

    localparam int reg_address_width = 1;
    localparam logic [reg_address_width-1:0] reg_data_address = 1'b0;
    localparam logic [reg_address_width-1:0] reg_command_address = 1'b1;

    localparam logic command_kind_access = 1'b0;
    localparam logic command_kind_config = 1'b1;

    // Both views keep kind in bit 31 so either can be used to tell them apart.
    typedef struct packed {
        logic                      kind;
        logic                      write;
        logic [13:0]               reserved;
        logic [hp0_addr_width-1:0] address;
    } access_view_t;

    typedef struct packed {
        logic                      kind;
        logic [14:0]               reserved;
        logic [hp0_addr_width-1:0] offset;
    } config_view_t;

    typedef union packed {
        access_view_t access_view;
        config_view_t config_view;
    } host_command_u;

endpackage
